/* design/beat_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// download FIFO
// buffers beats between the file channel and the valid/ready output
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "hb_config.svh"

module beat_fifo
	import hb_pkg::*;
#(
	parameter int DEPTH = `HB_FIFO_DEPTH
) (
	input  logic     clk_sys,
	input  logic     rst_n,
	input  logic     push_valid,
	input  dl_beat_t push_beat,
	input  logic     ioctl_ready,
	output logic     almost_full,
	output logic     ioctl_valid,
	output dl_beat_t pop_beat
);

	localparam int AW = $clog2(DEPTH);

	dl_beat_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          pop;
	logic          push_ok;

	assign ioctl_valid = (count != '0);
	assign pop_beat    = mem[rd_ptr];
	assign pop         = ioctl_valid && ioctl_ready;
	// a full FIFO still takes a beat when the head leaves in the same cycle
	assign push_ok     = push_valid && ((count != (AW+1)'(DEPTH)) || pop);
	// two slots of margin, one for the beat already on its way
	assign almost_full = (count >= (AW+1)'(DEPTH - 2));

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push_ok && !pop)
				count <= count + 1'b1;
			else if (pop && !push_ok)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push_ok)
			mem[wr_ptr] <= push_beat;
	end

endmodule

/* design/fio_loader.sv */
////////////////////////////////////////////////////////////////////////////
// file channel
// decodes fp_enable frames, tracks the download state and address
// and emits one beat per data word
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "hb_config.svh"

module fio_loader
	import hb_pkg::*;
(
	input  logic     clk_sys,
	input  logic     rst_n,
	input  logic     fp_enable,
	input  logic     io_strobe,
	input  word_t    io_din,
	output logic     push_valid,
	output dl_beat_t push_beat,
	output logic     ioctl_download,
	output word_t    ioctl_index
);

	localparam word_t FIO_TX     = {8'h00, `HB_FIO_TX};
	localparam word_t FIO_TX_DAT = {8'h00, `HB_FIO_TX_DAT};
	localparam word_t FIO_INDEX  = {8'h00, `HB_FIO_INDEX};

	logic                  has_cmd;
	word_t                 cmd;
	// arguments already taken in this frame, saturates at 3
	logic [1:0]            arg_idx;
	logic [`HB_ADDR_W-1:0] addr;
	logic                  arg_stb;
	logic                  tx_arg;
	logic                  idx_arg;
	logic                  dat_stb;

	assign arg_stb = fp_enable && io_strobe && has_cmd;
	assign tx_arg  = arg_stb && (cmd == FIO_TX);
	assign idx_arg = arg_stb && (cmd == FIO_INDEX);
	assign dat_stb = arg_stb && (cmd == FIO_TX_DAT) && ioctl_download;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			has_cmd        <= 1'b0;
			cmd            <= '0;
			arg_idx        <= '0;
			push_valid     <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
		end else begin
			push_valid <= dat_stb;

			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					cmd     <= io_din;
					has_cmd <= 1'b1;
					arg_idx <= '0;
				end else if (arg_idx != 2'd3) begin
					arg_idx <= arg_idx + 2'd1;
				end
			end

			// nonzero low byte starts, zero stops
			if (tx_arg && arg_idx == 2'd0)
				ioctl_download <= (io_din[7:0] != 8'h00);
			if (idx_arg && arg_idx == 2'd0)
				ioctl_index <= io_din;
		end
	end

	// address counter and beat payload
	always_ff @(posedge clk_sys) begin
		if (tx_arg) begin
			case (arg_idx)
				2'd0: if (io_din[7:0] != 8'h00)
					addr <= '0;
				2'd1: addr[15:0] <= io_din;
				2'd2: addr[`HB_ADDR_W-1:16] <= io_din[`HB_ADDR_W-17:0];
				default: ;
			endcase
		end
		if (dat_stb) begin
			push_beat.addr <= addr;
			push_beat.data <= io_din[7:0];
			addr           <= addr + 1'b1;
		end
	end

endmodule

/* design/hb_config.svh */
////////////////////////////////////////////////////////////////////////////
// host bridge configuration
// bus and address widths, download FIFO depth and the command codes
// of the user and file channels
////////////////////////////////////////////////////////////////////////////
`ifndef HB_CONFIG_SVH
`define HB_CONFIG_SVH

`define HB_WORD_W      16
`define HB_ADDR_W      27
`define HB_FIFO_DEPTH  8

// user channel commands
`define HB_CMD_CFG     8'h01
`define HB_CMD_JOY0    8'h02
`define HB_CMD_JOY1    8'h03
`define HB_CMD_STATUS  8'h1e
`define HB_CMD_STSET   8'h29
`define HB_CMD_INFO    8'h36

// file channel commands
`define HB_FIO_TX      8'h53
`define HB_FIO_TX_DAT  8'h54
`define HB_FIO_INDEX   8'h55
`endif

/* design/hb_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// host bridge types
// host word, status vector, joystick set and download beat
////////////////////////////////////////////////////////////////////////////
`include "hb_config.svh"

package hb_pkg;

	// one word of the host bus
	typedef logic [`HB_WORD_W-1:0] word_t;

	// status vector written by the host menu
	typedef logic [127:0] status_t;

	// up to 32 buttons per joystick
	typedef logic [31:0] joy_t;

	// one byte of a file download and where it goes
	typedef struct packed {
		logic [`HB_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} dl_beat_t;

endpackage

/* design/hb_top.sv */
////////////////////////////////////////////////////////////////////////////
// host command bridge
// turns host bus frames into core registers and a download byte stream
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "hb_config.svh"

module hb_top
	import hb_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst_n,
	// host bus
	input  logic                  io_enable,
	input  logic                  fp_enable,
	input  logic                  io_strobe,
	input  word_t                 io_din,
	output word_t                 io_dout,
	output logic                  io_wait,
	// core side registers
	input  status_t               status_in,
	input  logic                  status_set,
	input  logic                  info_req,
	input  logic [7:0]            info,
	output logic [1:0]            buttons,
	output logic                  forced_scandoubler,
	output logic                  direct_video,
	output joy_t                  joystick_0,
	output joy_t                  joystick_1,
	output status_t               status,
	// download stream
	output logic                  ioctl_download,
	output word_t                 ioctl_index,
	output logic                  ioctl_valid,
	input  logic                  ioctl_ready,
	output logic [`HB_ADDR_W-1:0] ioctl_addr,
	output logic [7:0]            ioctl_dout
);

	logic [3:0] req_count;
	status_t    req_status;
	logic [7:0] info_byte;
	logic       info_taken;
	logic       push_valid;
	dl_beat_t   push_beat;
	dl_beat_t   pop_beat;

	uio_regs i_uio_regs (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.req_count          (req_count),
		.req_status         (req_status),
		.info_byte          (info_byte),
		.io_dout            (io_dout),
		.info_taken         (info_taken),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	host_req i_host_req (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.status_set (status_set),
		.status_in  (status_in),
		.info_req   (info_req),
		.info       (info),
		.info_taken (info_taken),
		.req_count  (req_count),
		.req_status (req_status),
		.info_byte  (info_byte)
	);

	fio_loader i_fio_loader (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.fp_enable      (fp_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.push_valid     (push_valid),
		.push_beat      (push_beat),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index)
	);

	// almost full doubles as the host wait flag
	beat_fifo i_beat_fifo (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.push_valid  (push_valid),
		.push_beat   (push_beat),
		.ioctl_ready (ioctl_ready),
		.almost_full (io_wait),
		.ioctl_valid (ioctl_valid),
		.pop_beat    (pop_beat)
	);

	assign ioctl_addr = pop_beat.addr;
	assign ioctl_dout = pop_beat.data;

endmodule

/* design/host_req.sv */
////////////////////////////////////////////////////////////////////////////
// core request latch
// catches status_set and info_req edges for the host to read back
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module host_req
	import hb_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       status_set,
	input  status_t    status_in,
	input  logic       info_req,
	input  logic [7:0] info,
	input  logic       info_taken,
	output logic [3:0] req_count,
	output status_t    req_status,
	output logic [7:0] info_byte
);

	logic status_set_d;
	logic info_req_d;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			status_set_d <= 1'b0;
			info_req_d   <= 1'b0;
			req_count    <= '0;
			req_status   <= '0;
			info_byte    <= '0;
		end else begin
			status_set_d <= status_set;
			info_req_d   <= info_req;

			// counter wraps, the host only looks for a change
			if (status_set && !status_set_d) begin
				req_count  <= req_count + 4'd1;
				req_status <= status_in;
			end

			// a fresh request wins over a read in the same cycle
			if (info_req && !info_req_d)
				info_byte <= info;
			else if (info_taken)
				info_byte <= '0;
		end
	end

endmodule

/* design/uio_regs.sv */
////////////////////////////////////////////////////////////////////////////
// user channel
// decodes io_enable frames, holds the core registers the host writes
// and forms the registered replies on io_dout
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "hb_config.svh"

module uio_regs
	import hb_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       io_enable,
	input  logic       io_strobe,
	input  word_t      io_din,
	input  logic [3:0] req_count,
	input  status_t    req_status,
	input  logic [7:0] info_byte,
	output word_t      io_dout,
	output logic       info_taken,
	output logic [1:0] buttons,
	output logic       forced_scandoubler,
	output logic       direct_video,
	output joy_t       joystick_0,
	output joy_t       joystick_1,
	output status_t    status
);

	localparam word_t CMD_CFG    = {8'h00, `HB_CMD_CFG};
	localparam word_t CMD_JOY0   = {8'h00, `HB_CMD_JOY0};
	localparam word_t CMD_JOY1   = {8'h00, `HB_CMD_JOY1};
	localparam word_t CMD_STATUS = {8'h00, `HB_CMD_STATUS};
	localparam word_t CMD_STSET  = {8'h00, `HB_CMD_STSET};
	localparam word_t CMD_INFO   = {8'h00, `HB_CMD_INFO};

	word_t      cmd;
	// 0 while waiting for the command, then argument number
	logic [3:0] arg_cnt;
	logic [2:0] slice_sel;
	logic       in_slice;

	// arguments 1..8 map to 16-bit slices of a 128-bit vector
	assign slice_sel = 3'(arg_cnt - 4'd1);
	assign in_slice  = (arg_cnt != 4'd0) && (arg_cnt <= 4'd8);

	// the info byte is handed over on the command strobe itself
	assign info_taken = io_enable && io_strobe && (arg_cnt == 4'd0) && (io_din == CMD_INFO);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd                <= '0;
			arg_cnt            <= '0;
			io_dout            <= '0;
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
			direct_video       <= 1'b0;
			joystick_0         <= '0;
			joystick_1         <= '0;
			status             <= '0;
		end else if (!io_enable) begin
			cmd     <= '0;
			arg_cnt <= '0;
		end else if (io_strobe) begin
			io_dout <= '0;
			if (arg_cnt != 4'hf)
				arg_cnt <= arg_cnt + 4'd1;

			if (arg_cnt == 4'd0) begin
				cmd <= io_din;
				case (io_din)
					CMD_STSET: io_dout <= {8'h00, 4'ha, req_count};
					CMD_INFO:  io_dout <= {8'h00, info_byte};
					default: ;
				endcase
			end else begin
				case (cmd)
					CMD_CFG: if (arg_cnt == 4'd1) begin
						buttons            <= io_din[1:0];
						forced_scandoubler <= io_din[4];
						direct_video       <= io_din[10];
					end
					CMD_JOY0: begin
						if (arg_cnt == 4'd1)
							joystick_0[15:0] <= io_din;
						else if (arg_cnt == 4'd2)
							joystick_0[31:16] <= io_din;
					end
					CMD_JOY1: begin
						if (arg_cnt == 4'd1)
							joystick_1[15:0] <= io_din;
						else if (arg_cnt == 4'd2)
							joystick_1[31:16] <= io_din;
					end
					CMD_STATUS: if (in_slice)
						status[{slice_sel, 4'b0000} +: 16] <= io_din;
					// readback of the vector captured at the last status_set edge
					CMD_STSET: if (in_slice)
						io_dout <= req_status[{slice_sel, 4'b0000} +: 16];
					default: ;
				endcase
			end
		end
	end

endmodule

/* dv/tb_hb_model.svh */
////////////////////////////////////////////////////////////////////////////
// host bridge reference model
// random source, value check, expected registers, replies and beats
////////////////////////////////////////////////////////////////////////////
`ifndef TB_HB_MODEL_SVH
`define TB_HB_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'hc88d8049;
// x^32 + x^22 + x^2 + x + 1, right shifting form
localparam logic [31:0] LFSR_TAPS = 32'h80200003;

int          errors = 0;
int          checks = 0;
logic [31:0] lfsr_state  = LFSR_SEED;
logic [31:0] ready_state = LFSR_SEED;

// register and request state the host should see
status_t               exp_status = '0;
status_t               last_set   = '0;
int                    set_edges  = 0;

// download stream
logic [`HB_ADDR_W-1:0] dl_addr;
dl_beat_t              exp_beats [$];
dl_beat_t              head_beat;
int                    beats_seen = 0;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ LFSR_TAPS;
	return s >> 1;
endfunction

// one LFSR step for every bit handed out
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_state[0]};
		lfsr_state = lfsr_next(lfsr_state);
	end
	return v;
endfunction

function automatic status_t rand_status();
	status_t v;
	for (int i = 0; i < 4; i++)
		v[32*i +: 32] = rand_bits(32);
	return v;
endfunction

task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAILED %s: got %h, expected %h", name, got, exp);
	end
endtask

// each rising edge of status_set counts and captures the vector
task automatic note_status_set(input status_t v);
	set_edges++;
	last_set = v;
endtask

// reply to the STSET command word, count kept modulo 16
function automatic word_t stset_head();
	return {8'h00, 4'ha, 4'(set_edges % 16)};
endfunction

task automatic expect_beat(input logic [7:0] data);
	dl_beat_t b;
	b.addr = dl_addr;
	b.data = data;
	exp_beats.push_back(b);
	dl_addr = dl_addr + 1'b1;
endtask

`endif

/* dv/tb_hb_top.sv */
////////////////////////////////////////////////////////////////////////////
// host bridge testbench
// drives user and file channel frames, checks registers, replies
// and the download stream against a model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "hb_config.svh"

module tb_hb_top
	import hb_pkg::*;
();

	`include "tb_hb_model.svh"

	localparam int N_DATA     = 48;
	// strobes, frame overhead, status_set pulses and download beats
	localparam int SEQ_CYCLES = 40 * 4 + 10 * 2 + 16 * 2 + N_DATA * 4 + 16;
	localparam int TIMEOUT    = 4 * SEQ_CYCLES;

	logic                  clk_sys;
	logic                  rst_n;
	logic                  io_enable;
	logic                  fp_enable;
	logic                  io_strobe;
	word_t                 io_din;
	word_t                 io_dout;
	logic                  io_wait;
	status_t               status_in;
	logic                  status_set;
	logic                  info_req;
	logic [7:0]            info;
	logic [1:0]            buttons;
	logic                  forced_scandoubler;
	logic                  direct_video;
	joy_t                  joystick_0;
	joy_t                  joystick_1;
	status_t               status;
	logic                  ioctl_download;
	word_t                 ioctl_index;
	logic                  ioctl_valid;
	logic                  ioctl_ready;
	logic [`HB_ADDR_W-1:0] ioctl_addr;
	logic [7:0]            ioctl_dout;

	word_t args [0:15];
	word_t rsp  [0:15];
	int    cycles = 0;

	// FIFO level as the host sees it, a data strobe lands one cycle later
	int    fifo_level = 0;
	logic  push_due   = 1'b0;
	logic  dat_phase  = 1'b0;

	hb_top i_hb_top (.*);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////////////
	// host bus driver
	////////////////////////////////////////////////////////////////////////////

	// reply is registered, read it one cycle after the strobe
	task automatic strobe_word(input word_t w, output word_t reply);
		io_din    = w;
		io_strobe = 1'b1;
		@(negedge clk_sys);
		io_strobe = 1'b0;
		reply     = io_dout;
		repeat (rand_bits(2)) @(negedge clk_sys);
	endtask

	task automatic run_frame(input logic file_ch, input word_t cmd, input int n_args);
		word_t r;
		if (file_ch)
			fp_enable = 1'b1;
		else
			io_enable = 1'b1;
		@(negedge clk_sys);
		strobe_word(cmd, r);
		rsp[0] = r;
		for (int i = 1; i <= n_args; i++) begin
			strobe_word(args[i], r);
			rsp[i] = r;
		end
		io_enable = 1'b0;
		fp_enable = 1'b0;
		@(negedge clk_sys);
	endtask

	// data words only go out while io_wait is low
	task automatic send_data(input int n);
		word_t r;
		word_t w;
		fp_enable = 1'b1;
		@(negedge clk_sys);
		strobe_word({8'h00, `HB_FIO_TX_DAT}, r);
		dat_phase = 1'b1;
		for (int i = 0; i < n; i++) begin
			while (io_wait)
				@(negedge clk_sys);
			w = 16'(rand_bits(16));
			expect_beat(w[7:0]);
			strobe_word(w, r);
		end
		dat_phase = 1'b0;
		fp_enable = 1'b0;
		@(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// core side: random back-pressure and the download monitor
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic rdy;
		ioctl_ready = 1'b0;
		forever begin
			@(negedge clk_sys);
			// ready on about one cycle in four so the FIFO backs up
			rdy         = ready_state[0];
			ready_state = lfsr_next(ready_state);
			ioctl_ready = rdy && ready_state[0];
			ready_state = lfsr_next(ready_state);
		end
	end

	always @(posedge clk_sys) begin
		if (rst_n) begin
			check_val("io_wait", io_wait, fifo_level >= `HB_FIFO_DEPTH - 2);
			if (ioctl_valid && ioctl_ready) begin
				if (exp_beats.size() == 0) begin
					errors++;
					$display("download beat at address %h arrived with none expected",
						ioctl_addr);
				end else begin
					head_beat = exp_beats.pop_front();
					check_val("ioctl_addr", ioctl_addr, head_beat.addr);
					check_val("ioctl_dout", ioctl_dout, head_beat.data);
				end
				beats_seen++;
				fifo_level--;
			end
			if (push_due)
				fifo_level++;
			push_due = fp_enable && io_strobe && dat_phase;
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			errors++;
			$display("timeout, the test sequence did not finish in %0d cycles", TIMEOUT);
			$display("%0d checks, %0d errors", checks, errors);
			$display("Test FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [7:0] info_val;
		int         n_set;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		info_req   = 1'b0;
		info       = '0;
		rst_n      = 1'b0;
		repeat (3) @(negedge clk_sys);
		rst_n = 1'b1;

		check_val("ioctl_valid", ioctl_valid, 0);
		check_val("ioctl_download", ioctl_download, 0);
		check_val("io_wait", io_wait, 0);
		check_val("status", status, 0);

		// configuration word
		args[1] = 16'(rand_bits(16));
		run_frame(1'b0, {8'h00, `HB_CMD_CFG}, 1);
		check_val("buttons", buttons, args[1][1:0]);
		check_val("forced_scandoubler", forced_scandoubler, args[1][4]);
		check_val("direct_video", direct_video, args[1][10]);

		// joysticks, low half first
		args[1] = 16'(rand_bits(16));
		args[2] = 16'(rand_bits(16));
		run_frame(1'b0, {8'h00, `HB_CMD_JOY0}, 2);
		check_val("joystick_0", joystick_0, {args[2], args[1]});
		args[1] = 16'(rand_bits(16));
		args[2] = 16'(rand_bits(16));
		run_frame(1'b0, {8'h00, `HB_CMD_JOY1}, 2);
		check_val("joystick_1", joystick_1, {args[2], args[1]});

		// status vector, lowest slice first
		for (int i = 1; i <= 8; i++) begin
			args[i] = 16'(rand_bits(16));
			exp_status[16*(i-1) +: 16] = args[i];
		end
		run_frame(1'b0, {8'h00, `HB_CMD_STATUS}, 8);
		check_val("status", status, exp_status);

		// status_set edges, then read back count and captured vector
		n_set = 1 + int'(rand_bits(4));
		repeat (n_set) begin
			status_in  = rand_status();
			status_set = 1'b1;
			@(negedge clk_sys);
			status_set = 1'b0;
			note_status_set(status_in);
			@(negedge clk_sys);
		end
		for (int i = 1; i <= 8; i++)
			args[i] = '0;
		run_frame(1'b0, {8'h00, `HB_CMD_STSET}, 8);
		check_val("io_dout", rsp[0], stset_head());
		for (int i = 1; i <= 8; i++)
			check_val("io_dout", rsp[i], last_set[16*(i-1) +: 16]);

		// info byte is cleared once read
		info_val = {7'(rand_bits(7)), 1'b1};
		info     = info_val;
		info_req = 1'b1;
		@(negedge clk_sys);
		info_req = 1'b0;
		@(negedge clk_sys);
		run_frame(1'b0, {8'h00, `HB_CMD_INFO}, 0);
		check_val("io_dout", rsp[0], {8'h00, info_val});
		run_frame(1'b0, {8'h00, `HB_CMD_INFO}, 0);
		check_val("io_dout", rsp[0], 0);

		// file index, download start at a random address
		args[1] = 16'(rand_bits(16));
		run_frame(1'b1, {8'h00, `HB_FIO_INDEX}, 1);
		check_val("ioctl_index", ioctl_index, args[1]);
		args[1] = {8'(rand_bits(8)), 7'(rand_bits(7)), 1'b1};
		args[2] = 16'(rand_bits(16));
		args[3] = {5'b00000, 11'(rand_bits(11))};
		run_frame(1'b1, {8'h00, `HB_FIO_TX}, 3);
		dl_addr = {args[3][10:0], args[2]};
		check_val("ioctl_download", ioctl_download, 1);

		send_data(N_DATA);
		while (exp_beats.size() != 0)
			@(negedge clk_sys);
		check_val("beats_seen", beats_seen, N_DATA);
		check_val("ioctl_download", ioctl_download, 1);

		// zero low byte stops the download
		args[1] = {8'(rand_bits(8)), 8'h00};
		run_frame(1'b1, {8'h00, `HB_FIO_TX}, 1);
		check_val("ioctl_download", ioctl_download, 0);
		check_val("ioctl_valid", ioctl_valid, 0);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the host bridge testbench with Verilator and run it
# the run fails on a build error, a crash or a failure line in the log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_hb_top \
	-Mdir obj_dir -o tb_hb_top > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_hb_top > sim.log 2>&1 && cat sim.log || { cat sim.log; exit 1; }
grep -q "Test FAILED" sim.log && exit 1
exit 0

/* vlog.f */
+incdir+design
+incdir+dv
design/hb_pkg.sv
design/uio_regs.sv
design/host_req.sv
design/fio_loader.sv
design/beat_fifo.sv
design/hb_top.sv
dv/tb_hb_top.sv
